/* common/fetch_pkg.sv */
// Shared types for the START_OP fetch decoder.
// Holds the operation, group and fetch state codes,
// the first instruction word views and the hazard flags.
`default_nettype none

package fetch_pkg;

    typedef enum logic [6:0] {
        // Trap-type operations.
        ILLEGAL, RTE, TRAP, UNIMPLEMENTED,
        // Register-only operations.
        DBcc, EXT, EXTB, MOVEQ, SWAP,
        EXG,
        // Status register writers.
        ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
        ORI_TO_CCR, ORI_TO_SR, OP_RESET,
        // Shifts and rotates.
        ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR,
        // ALU operations with a destination operand.
        ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
        NEG, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ, TST,
        // Source operand operations.
        ADDA, CMPA, SUBA, MOVEA, CHK, DIVS, DIVU, MULS, MULU, BTST,
        MOVE,
        // Flow and no-operation codes.
        BRA, Bcc, NOP, TRAPV
    } op_t;

    typedef enum logic [4:0] {
        START_OP       = 5'd0,
        CALC_AEFF      = 5'd1,
        FETCH_DISPL    = 5'd2,
        FETCH_EXWORD_1 = 5'd3,
        FETCH_ABS_HI   = 5'd8,
        FETCH_ABS_LO   = 5'd9,
        FETCH_IDATA_B2 = 5'd10,
        FETCH_IDATA_B1 = 5'd11,
        FETCH_OPERAND  = 5'd13,
        INIT_EXEC_WB   = 5'd14
    } fetch_state_t;

    typedef enum logic [3:0] {
        GRP_TRAP,
        GRP_REG,
        GRP_EXG,
        GRP_SR,
        GRP_SHIFT,
        GRP_ALU_DST,
        GRP_SRC,
        GRP_MOVE,
        GRP_DEFAULT
    } op_group_t;

    typedef struct packed {
        logic [7:0] upper;    // Bits 13..6, size and opmode fields.
        logic [2:0] ea_mode;
        logic [2:0] ea_reg;
    } biw0_ea_t;

    typedef struct packed {
        logic [1:0] size;     // 01 byte, 11 word, 10 long.
        logic [2:0] dst_reg;
        logic [2:0] dst_mode;
        logic [2:0] src_mode;
        logic [2:0] src_reg;
    } biw0_move_t;

    typedef struct packed {
        logic [5:0] upper;
        logic [4:0] opmode;   // Selects Dn/Dn, An/An or Dn/An exchange.
        logic [2:0] ry;
    } biw0_exg_t;

    // First instruction word, read as EA, MOVE or EXG encoding.
    typedef union packed {
        biw0_ea_t   ea_view;
        biw0_move_t move_view;
        biw0_exg_t  exg_view;
    } biw0_t;

    typedef struct packed {
        logic dr_in_use;      // Data register write pending.
        logic ar_in_use;      // Address register write pending.
        logic alu_bsy;
    } hazard_t;

    typedef struct packed {
        op_group_t group;
        logic      strict_hazard; // Register direct waits on either flag.
    } op_class_t;

endpackage

`default_nettype wire

/* fetch_start/ea_route.sv */
// Effective address router.
// Picks the next fetch state for groups that walk an EA field,
// holding in START_OP while a needed register is still pending.
`timescale 1ns/1ns
`default_nettype none

module ea_route (
    input  wire fetch_pkg::op_class_t op_class,
    input  wire fetch_pkg::biw0_t     biw_0,
    input  wire fetch_pkg::hazard_t   hazard,
    input  wire logic                 imm_long,
    output      fetch_pkg::fetch_state_t ea_state
);

    import fetch_pkg::*;

    logic         any_busy;
    fetch_state_t dn_state;
    fetch_state_t an_state;

    assign any_busy = hazard.dr_in_use || hazard.ar_in_use;

    // Register direct modes, which depend on the group.
    always_comb begin : reg_direct
        case (op_class.group)
            GRP_ALU_DST: begin
                if (hazard.dr_in_use) begin
                    dn_state = START_OP; // Wait, destination Dn.
                end else begin
                    dn_state = INIT_EXEC_WB;
                end
                if ((op_class.strict_hazard && any_busy) || hazard.ar_in_use) begin
                    an_state = START_OP;
                end else begin
                    an_state = INIT_EXEC_WB;
                end
            end
            GRP_SRC: begin
                if ((op_class.strict_hazard && any_busy) || hazard.dr_in_use) begin
                    dn_state = START_OP;
                end else begin
                    dn_state = INIT_EXEC_WB;
                end
                if (hazard.ar_in_use) begin
                    an_state = START_OP; // Source An pending.
                end else begin
                    an_state = INIT_EXEC_WB;
                end
            end
            GRP_MOVE: begin
                // A -(An) destination is decremented right away.
                if (hazard.dr_in_use ||
                    (biw_0.move_view.dst_mode == 3'b100 && hazard.ar_in_use)) begin
                    dn_state = START_OP;
                end else begin
                    dn_state = INIT_EXEC_WB;
                end
                if (hazard.ar_in_use) begin
                    an_state = START_OP;
                end else begin
                    an_state = INIT_EXEC_WB;
                end
            end
            default: begin
                dn_state = INIT_EXEC_WB;
                an_state = INIT_EXEC_WB;
            end
        endcase
    end

    always_comb begin : mode_dec
        case (biw_0.ea_view.ea_mode)
            3'b000: ea_state = dn_state;
            3'b001: ea_state = an_state;
            3'b010, 3'b011: begin // (An), (An)+.
                if (hazard.ar_in_use) begin
                    ea_state = START_OP;
                end else begin
                    ea_state = FETCH_OPERAND;
                end
            end
            3'b100: begin // -(An).
                if (hazard.ar_in_use) begin
                    ea_state = START_OP;
                end else begin
                    ea_state = CALC_AEFF;
                end
            end
            3'b101: ea_state = FETCH_DISPL;
            3'b110: ea_state = FETCH_EXWORD_1;
            default: begin
                case (biw_0.ea_view.ea_reg)
                    3'b000: ea_state = FETCH_ABS_LO; // Absolute short.
                    3'b001: ea_state = FETCH_ABS_HI; // Absolute long.
                    3'b100: begin
                        if (imm_long) begin
                            ea_state = FETCH_IDATA_B2;
                        end else begin
                            ea_state = FETCH_IDATA_B1; // Word or byte.
                        end
                    end
                    3'b010: ea_state = FETCH_DISPL; // PC relative.
                    default: ea_state = FETCH_EXWORD_1;
                endcase
            end
        endcase

        // Memory shifts only see absolute forms in these modes.
        if (op_class.group == GRP_SHIFT &&
            biw_0.ea_view.ea_mode inside {3'b000, 3'b001, 3'b111}) begin
            if (biw_0.ea_view.ea_reg == 3'b000) begin
                ea_state = FETCH_ABS_LO;
            end else begin
                ea_state = FETCH_ABS_HI;
            end
        end
    end

endmodule

`default_nettype wire

/* fetch_start/imm_size_dec.sv */
// Immediate size decoder.
// Flags a long word immediate source straight from the opcode bits.
`timescale 1ns/1ns
`default_nettype none

module imm_size_dec (
    input  wire fetch_pkg::op_t       op,
    input  wire fetch_pkg::op_class_t op_class,
    input  wire fetch_pkg::biw0_t     biw_0,
    output logic                      imm_long
);

    import fetch_pkg::*;

    always_comb begin : size_dec
        imm_long = 1'b0;
        case (op_class.group)
            GRP_ALU_DST: begin
                imm_long = (biw_0.ea_view.upper[1:0] == 2'b10); // Size in bits 7..6.
            end
            GRP_MOVE: begin
                imm_long = (biw_0.move_view.size == 2'b10);
            end
            GRP_SRC: begin
                case (op)
                    MOVEA:            imm_long = (biw_0.move_view.size == 2'b10);
                    ADDA, CMPA, SUBA: imm_long = (biw_0.ea_view.upper[2:1] == 2'b11);
                    CHK:              imm_long = (biw_0.ea_view.upper[2:1] == 2'b10);
                    DIVS, DIVU,
                    MULS, MULU:       imm_long = !biw_0.ea_view.upper[1]; // Long form.
                    default:          imm_long = 1'b0; // BTST takes a byte.
                endcase
            end
            default: begin
                imm_long = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* fetch_start/op_classify.sv */
// Operation classifier for the START_OP decoder.
// Sorts each operation into its routing group.
`timescale 1ns/1ns
`default_nettype none

module op_classify (
    input  wire fetch_pkg::op_t       op,
    output      fetch_pkg::op_class_t op_class
);

    import fetch_pkg::*;

    always_comb begin : group_dec
        case (op)
            ILLEGAL, RTE, TRAP, UNIMPLEMENTED: begin
                op_class.group = GRP_TRAP;
            end
            DBcc, EXT, EXTB, MOVEQ, SWAP: begin
                op_class.group = GRP_REG;
            end
            EXG: begin
                op_class.group = GRP_EXG;
            end
            ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
            ORI_TO_CCR, ORI_TO_SR, OP_RESET: begin
                op_class.group = GRP_SR; // Wait for condition codes.
            end
            ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR: begin
                op_class.group = GRP_SHIFT;
            end
            ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
            NEG, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ, TST: begin
                op_class.group = GRP_ALU_DST; // Destination is an ALU operand.
            end
            ADDA, CMPA, SUBA, MOVEA, CHK, DIVS, DIVU, MULS, MULU, BTST: begin
                op_class.group = GRP_SRC;
            end
            MOVE: begin
                op_class.group = GRP_MOVE;
            end
            default: begin
                op_class.group = GRP_DEFAULT; // Branches, NOP and unused codes.
            end
        endcase
    end

    // These read a register that another pending write may still target.
    always_comb begin : strict_dec
        op_class.strict_hazard = op inside {ADD, SUB, AND_B, EOR, OR_B, CMP,
                                            ADDA, SUBA, CMPA, MOVEA};
    end

endmodule

`default_nettype wire

/* fetch_start/start_op_route.sv */
// START_OP final next-state selection.
// Handles word availability, the register, EXG and status register
// groups, and passes the EA route through for the others.
`timescale 1ns/1ns
`default_nettype none

module start_op_route (
    input  wire fetch_pkg::op_class_t    op_class,
    input  wire fetch_pkg::biw0_t        biw_0,
    input  wire logic                    opd_ack,
    input  wire logic                    ow_rdy,
    input  wire fetch_pkg::hazard_t      hazard,
    input  wire fetch_pkg::fetch_state_t ea_state,
    output      fetch_pkg::fetch_state_t next_fetch_state
);

    import fetch_pkg::*;

    logic exg_wait;

    // Each exchange form waits on the register kinds it touches.
    assign exg_wait =
        (biw_0.exg_view.opmode == 5'b10001 && (hazard.dr_in_use || hazard.ar_in_use)) ||
        (biw_0.exg_view.opmode == 5'b01000 && hazard.dr_in_use) ||
        (biw_0.exg_view.opmode == 5'b01001 && hazard.ar_in_use);

    always_comb begin : start_dec
        if (!opd_ack && !ow_rdy) begin
            next_fetch_state = START_OP; // No word yet.
        end else begin
            case (op_class.group)
                GRP_TRAP: next_fetch_state = START_OP;
                GRP_REG: begin
                    if (hazard.dr_in_use) begin
                        next_fetch_state = START_OP;
                    end else begin
                        next_fetch_state = INIT_EXEC_WB;
                    end
                end
                GRP_EXG: begin
                    if (exg_wait) begin
                        next_fetch_state = START_OP;
                    end else begin
                        next_fetch_state = INIT_EXEC_WB;
                    end
                end
                GRP_SR: begin
                    if (hazard.alu_bsy) begin
                        next_fetch_state = START_OP; // Flags still in flight.
                    end else begin
                        next_fetch_state = INIT_EXEC_WB;
                    end
                end
                GRP_SHIFT: begin
                    if (biw_0.ea_view.upper[1:0] != 2'b11) begin // Register shift.
                        if (hazard.dr_in_use) begin
                            next_fetch_state = START_OP;
                        end else begin
                            next_fetch_state = INIT_EXEC_WB;
                        end
                    end else begin
                        next_fetch_state = ea_state; // Memory shift.
                    end
                end
                GRP_ALU_DST, GRP_SRC, GRP_MOVE: next_fetch_state = ea_state;
                default: next_fetch_state = INIT_EXEC_WB;
            endcase
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the START_OP decoder testbench with Verilator.
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_fetch_start -o tb_fetch_start &&
./obj_dir/tb_fetch_start | tee /dev/stderr | grep -q "Test OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb.f */
+incdir+tests
common/fetch_pkg.sv
fetch_start/op_classify.sv
fetch_start/imm_size_dec.sv
fetch_start/ea_route.sv
fetch_start/start_op_route.sv
verilog/fetch_start_dec.sv
tests/tb_fetch_start.sv

/* tests/fetch_start_model.svh */
// Reference model for the START_OP next-state decoder.
// Restates the routing rules on the raw 14-bit first instruction word.
`ifndef FETCH_START_MODEL_SVH
`define FETCH_START_MODEL_SVH

function automatic logic is_alu_dst(input op_t op);
    return op inside {ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI,
                      NEG, NOT_B, OR_B, ORI, SUB, SUBI, SUBQ, TST};
endfunction

function automatic logic is_src(input op_t op);
    return op inside {ADDA, CMPA, SUBA, MOVEA, CHK, DIVS, DIVU, MULS, MULU, BTST};
endfunction

function automatic logic is_shift(input op_t op);
    return op inside {ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR};
endfunction

function automatic logic imm_is_long(input op_t op, input logic [13:0] w);
    logic is_long;
    is_long = 1'b0;                              // BTST and the rest take short data.
    if (is_alu_dst(op)) begin
        is_long = (w[7:6] == 2'b10);
    end else if (op == MOVE || op == MOVEA) begin
        is_long = (w[13:12] == 2'b10);
    end else if (op inside {ADDA, CMPA, SUBA}) begin
        is_long = (w[8:7] == 2'b11);
    end else if (op == CHK) begin
        is_long = (w[8:7] == 2'b10);
    end else if (op inside {DIVS, DIVU, MULS, MULU}) begin
        is_long = !w[7];
    end
    return is_long;
endfunction

// Next state for the groups that walk the EA field.
function automatic fetch_state_t ea_expect(input op_t op, input logic [13:0] w,
                                           input hazard_t hz);
    fetch_state_t st;
    logic [2:0]   mode;
    logic [2:0]   rg;
    logic         dr;
    logic         ar;
    logic         strict_wait;
    mode = w[5:3];
    rg = w[2:0];
    dr = hz.dr_in_use;
    ar = hz.ar_in_use;
    strict_wait = (op inside {ADD, SUB, AND_B, EOR, OR_B, CMP, ADDA, SUBA, CMPA, MOVEA})
                  && (dr || ar);
    case (mode)
        3'b000: begin
            if (is_alu_dst(op)) begin
                st = dr ? START_OP : INIT_EXEC_WB;
            end else if (is_src(op)) begin
                st = (strict_wait || dr) ? START_OP : INIT_EXEC_WB;
            end else begin
                st = (dr || (w[8:6] == 3'b100 && ar)) ? START_OP : INIT_EXEC_WB;
            end
        end
        3'b001: begin
            if (is_alu_dst(op)) begin
                st = (strict_wait || ar) ? START_OP : INIT_EXEC_WB;
            end else begin
                st = ar ? START_OP : INIT_EXEC_WB;
            end
        end
        3'b010, 3'b011: st = ar ? START_OP : FETCH_OPERAND;
        3'b100: st = ar ? START_OP : CALC_AEFF;
        3'b101: st = FETCH_DISPL;
        3'b110: st = FETCH_EXWORD_1;
        default: begin
            case (rg)
                3'b000: st = FETCH_ABS_LO;
                3'b001: st = FETCH_ABS_HI;
                3'b010: st = FETCH_DISPL;
                3'b100: st = imm_is_long(op, w) ? FETCH_IDATA_B2 : FETCH_IDATA_B1;
                default: st = FETCH_EXWORD_1;
            endcase
        end
    endcase
    if (is_shift(op) && mode inside {3'b000, 3'b001, 3'b111}) begin
        st = (rg == 3'b000) ? FETCH_ABS_LO : FETCH_ABS_HI;
    end
    return st;
endfunction

function automatic fetch_state_t expected_state(input op_t op, input logic [13:0] w,
                                                input logic ack, input logic rdy,
                                                input hazard_t hz);
    fetch_state_t st;
    logic [4:0]   opmode;
    opmode = w[7:3];
    st = INIT_EXEC_WB;                           // Branches, NOP and unlisted codes.
    if (!ack && !rdy) begin
        st = START_OP;
    end else if (op inside {ILLEGAL, RTE, TRAP, UNIMPLEMENTED}) begin
        st = START_OP;
    end else if (op inside {DBcc, EXT, EXTB, MOVEQ, SWAP}) begin
        st = hz.dr_in_use ? START_OP : INIT_EXEC_WB;
    end else if (op == EXG) begin
        if ((opmode == 5'b10001 && (hz.dr_in_use || hz.ar_in_use)) ||
            (opmode == 5'b01000 && hz.dr_in_use) ||
            (opmode == 5'b01001 && hz.ar_in_use)) begin
            st = START_OP;
        end
    end else if (op inside {ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
                            ORI_TO_CCR, ORI_TO_SR, OP_RESET}) begin
        st = hz.alu_bsy ? START_OP : INIT_EXEC_WB;
    end else if (is_shift(op) && w[7:6] != 2'b11) begin
        st = hz.dr_in_use ? START_OP : INIT_EXEC_WB; // Register shift.
    end else if (is_shift(op) || is_alu_dst(op) || is_src(op) || op == MOVE) begin
        st = ea_expect(op, w, hz);
    end
    return st;
endfunction

`endif

/* tests/tb_fetch_start.sv */
// Testbench for the START_OP next-state decoder.
// Drives LFSR driven random vectors and checks each against a model.
`timescale 1ns/1ns
`default_nettype none

module tb_fetch_start;

    import fetch_pkg::*;

    `include "fetch_start_model.svh"

    localparam int MAX_CYCLES = 5000;

    logic         clk;
    logic         rst_n;
    op_t          op;
    biw0_t        biw_0;
    logic         opd_ack;
    logic         ow_rdy;
    hazard_t      hazard;
    fetch_state_t next_fetch_state;

    logic [31:0]  lfsr;
    int           errors;
    int           checks;

    op_t nonea_ops [0:20] = '{ILLEGAL, RTE, TRAP, UNIMPLEMENTED, DBcc, EXT, EXTB, MOVEQ,
                              SWAP, EXG, ANDI_TO_CCR, ANDI_TO_SR, EORI_TO_CCR, EORI_TO_SR,
                              ORI_TO_CCR, ORI_TO_SR, OP_RESET, BRA, Bcc, NOP, TRAPV};
    op_t ea_ops [0:27] = '{ADD, ADDI, ADDQ, AND_B, ANDI, CMP, CMPI, EOR, EORI, NEG, NOT_B,
                           OR_B, ORI, SUB, SUBI, SUBQ, TST, ADDA, CMPA, SUBA, MOVEA, CHK,
                           DIVS, DIVU, MULS, MULU, BTST, MOVE};
    op_t shift_ops [0:7] = '{ASL, ASR, LSL, LSR, ROTL, ROTR, ROXL, ROXR};

    fetch_start_dec UUT (
        .op               (op),
        .biw_0            (biw_0),
        .opd_ack          (opd_ack),
        .ow_rdy           (ow_rdy),
        .hazard           (hazard),
        .next_fetch_state (next_fetch_state)
    );

    initial begin : clk_gen
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Taps 32, 22, 2, 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);              // One step per bit.
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // At least one of opd_ack and ow_rdy is set.
    function automatic logic [1:0] word_avail();
        logic [1:0] av;
        av = 2'(rand_bits(2));
        if (av == 2'b00) begin
            av = 2'b01;
        end
        return av;
    endfunction

    task automatic apply_vector(input string test, input op_t op_v, input logic [13:0] w,
                                input logic ack_v, input logic rdy_v, input hazard_t hz_v);
        fetch_state_t expected;
        logic         ack_g;
        logic         rdy_g;
        @(posedge clk);
        #1;
        ack_g = ack_v && rst_n;                  // Idle while in reset.
        rdy_g = rdy_v && rst_n;
        op = op_v;
        biw_0 = w;
        opd_ack = ack_g;
        ow_rdy = rdy_g;
        hazard = hz_v;
        @(negedge clk);                          // Output settled mid cycle.
        expected = expected_state(op_v, w, ack_g, rdy_g, hz_v);
        checks++;
        assert (next_fetch_state === expected) else begin
            errors++;
            $display("FAILED %s: op %0d biw %h ack %b rdy %b hazard %b", test, op_v, w,
                     ack_g, rdy_g, hz_v);
            $display("FAILED %s: expected %s (%0d) actual %s (%0d)", test, expected.name(),
                     expected, next_fetch_state.name(), next_fetch_state);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run did not finish within %0d clock cycles.", MAX_CYCLES);
        $display("Test FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [13:0] w;
        logic [1:0]  av;
        int          code;
        rst_n = 1'b0;
        op = ILLEGAL;
        biw_0 = '0;
        opd_ack = 1'b0;
        ow_rdy = 1'b0;
        hazard = '0;
        lfsr = 32'hc15d;
        errors = 0;
        checks = 0;

        // Word requests are held off while in reset.
        for (int i = 0; i < 16; i++) begin
            apply_vector("reset_idle", op_t'(7'(rand_bits(7))), 14'(rand_bits(14)),
                         1'(rand_bits(1)), 1'(rand_bits(1)), hazard_t'(3'(rand_bits(3))));
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < 40; i++) begin
            apply_vector("reset_idle", op_t'(7'(rand_bits(7))), 14'(rand_bits(14)),
                         1'b0, 1'b0, hazard_t'(3'(rand_bits(3))));
        end

        for (int i = 0; i < 200; i++) begin
            w = 14'(rand_bits(14));
            if (rand_bits(1) == 1) begin
                w[7:3] = (rand_bits(1) == 1) ? 5'b10001 : {4'b0100, 1'(rand_bits(1))};
            end
            av = word_avail();
            apply_vector("reg_groups", nonea_ops[5'(rand_bits(8) % 21)], w, av[1], av[0],
                         hazard_t'(3'(rand_bits(3))));
        end

        // Every mode and register for the ALU and source groups.
        for (int k = 0; k < 27; k++) begin
            for (int m = 0; m < 64; m++) begin
                w = 14'(rand_bits(14));
                w[5:0] = m[5:0];
                av = word_avail();
                apply_vector("ea_modes", ea_ops[k], w, av[1], av[0],
                             hazard_t'(3'(rand_bits(3))));
            end
        end

        for (int k = 0; k < 28; k++) begin
            for (int i = 0; i < 8; i++) begin
                w = 14'(rand_bits(14));
                w[5:0] = 6'b111100;              // Immediate source.
                av = word_avail();
                apply_vector("immediate_size", ea_ops[k], w, av[1], av[0],
                             hazard_t'(3'(rand_bits(3))));
            end
        end

        for (int i = 0; i < 200; i++) begin
            w = 14'(rand_bits(14));
            if (rand_bits(1) == 1) begin
                w[8:6] = 3'b100;                 // Predecrement destination.
            end
            av = word_avail();
            apply_vector("move_and_shift", MOVE, w, av[1], av[0],
                         hazard_t'(3'(rand_bits(3))));
        end
        for (int i = 0; i < 200; i++) begin
            w = 14'(rand_bits(14));
            if (rand_bits(1) == 1) begin
                w[7:6] = 2'b11;                  // Memory form.
            end
            av = word_avail();
            apply_vector("move_and_shift", shift_ops[3'(rand_bits(3))], w, av[1], av[0],
                         hazard_t'(3'(rand_bits(3))));
        end

        for (int i = 0; i < 100; i++) begin
            code = 57 + int'(rand_bits(7) % 71);
            av = word_avail();
            apply_vector("unlisted_codes", op_t'(code[6:0]), 14'(rand_bits(14)), av[1],
                         av[0], hazard_t'(3'(rand_bits(3))));
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/fetch_start_dec.sv */
// START_OP next-state decoder top level.
// Connects the classifier, immediate size decoder and both routers.
`timescale 1ns/1ns
`default_nettype none

module fetch_start_dec (
    input  wire fetch_pkg::op_t          op,
    input  wire fetch_pkg::biw0_t        biw_0,
    input  wire logic                    opd_ack,
    input  wire logic                    ow_rdy,
    input  wire fetch_pkg::hazard_t      hazard,
    output      fetch_pkg::fetch_state_t next_fetch_state
);

    import fetch_pkg::*;

    op_class_t    op_class;
    logic         imm_long;
    fetch_state_t ea_state;

    op_classify u_op_classify (
        .op       (op),
        .op_class (op_class)
    );

    imm_size_dec u_imm_size_dec (
        .op       (op),
        .op_class (op_class),
        .biw_0    (biw_0),
        .imm_long (imm_long)
    );

    ea_route u_ea_route (
        .op_class (op_class),
        .biw_0    (biw_0),
        .hazard   (hazard),
        .imm_long (imm_long),
        .ea_state (ea_state)
    );

    start_op_route u_start_op_route (
        .op_class         (op_class),
        .biw_0            (biw_0),
        .opd_ack          (opd_ack),
        .ow_rdy           (ow_rdy),
        .hazard           (hazard),
        .ea_state         (ea_state),
        .next_fetch_state (next_fetch_state)
    );

endmodule

`default_nettype wire
